//--- test/mdStimulus.txt
# name funct rs rt expected flush; all hex except flush (0 or 1)
# expected is compared only on MFHI (10) and MFLO (12) lines
rstHi       10 00000000 00000000 00000000 0
rstLo       12 00000000 00000000 00000000 0
mthiSet     11 12345678 00000000 00000000 0
mtloSet     13 9abcdef0 00000000 00000000 0
mthiRead    10 00000000 00000000 12345678 0
mtloRead    12 00000000 00000000 9abcdef0 0
multMixed   18 fffffffd 00000007 00000000 0
multHi      10 00000000 00000000 ffffffff 0
multLo      12 00000000 00000000 ffffffeb 0
multuMixed  19 fffffffd 00000007 00000000 0
multuHi     10 00000000 00000000 00000006 0
multuLo     12 00000000 00000000 ffffffeb 0
divNegPos   1a ffffff9c 00000007 00000000 0
divNegPosLo 12 00000000 00000000 fffffff2 0
divNegPosHi 10 00000000 00000000 fffffffe 0
divPosNeg   1a 00000064 fffffff9 00000000 0
divPosNegLo 12 00000000 00000000 fffffff2 0
divPosNegHi 10 00000000 00000000 00000002 0
divNegNeg   1a ffffff9c fffffff9 00000000 0
divNegNegLo 12 00000000 00000000 0000000e 0
divNegNegHi 10 00000000 00000000 fffffffe 0
divuBig     1b ffffff9c 00000007 00000000 0
divuBigLo   12 00000000 00000000 24924916 0
divuBigHi   10 00000000 00000000 00000002 0
divZero     1a 00001234 00000000 00000000 0
divZeroHi   10 00000000 00000000 00000000 0
divZeroLo   12 00000000 00000000 00000000 0
keepHi      11 11111111 00000000 00000000 0
keepLo      13 22222222 00000000 00000000 0
divFlush    1a 00000064 00000007 00000000 1
flushHi     10 00000000 00000000 11111111 0
flushLo     12 00000000 00000000 22222222 0
divuAfter   1b 00000064 00000007 00000000 0
divuAfterLo 12 00000000 00000000 0000000e 0
divuAfterHi 10 00000000 00000000 00000002 0

//--- list.f
src/mdPkg.sv
src/mdIf.sv
src/mdDecode.sv
src/mdDivider.sv
src/mdExecute.sv
src/mdResult.sv
src/mdUnit.sv
test/mdUnitTb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run from the project root, status follows the pass line
verilator --binary --timing --assert -f list.f --top-module mdUnitTb -o mdUnitSim &&
    ./obj_dir/mdUnitSim | tee /dev/stderr | grep -q -F "Simulation finished: PASS" &&
    echo "Run passed" || { echo "Run failed"; exit 1; }

//--- test/mdUnitTb.sv
/*
 * Testbench for the multiply/divide unit
 * Replays instructions from a stimulus file, applies random output back-pressure
 * and checks every MF response against the expected value, in order
 */
`timescale 1ns/1ps

module mdUnitTb;
    import mdPkg::*;

    logic             clk;
    logic             rst;
    logic             flush;
    logic             inValid;
    logic             inReady;
    logic [5:0]       funct;
    logic [dataW-1:0] rs;
    logic [dataW-1:0] rt;
    logic             outValid;
    logic             outReady;
    logic [dataW-1:0] outData;

    string            names[$];
    logic [5:0]       functs[$];
    logic [dataW-1:0] rsVals[$];
    logic [dataW-1:0] rtVals[$];
    logic [dataW-1:0] expVals[$];
    int               flushFlags[$];

    logic [dataW-1:0] expQ[$];          // Outstanding MF results, oldest first
    string            expNameQ[$];

    int cycles;
    int cycleLimit;
    int checked;
    int errors;

    mdUnit i_mdUnit (
        .clk      (clk),
        .rst      (rst),
        .flush    (flush),
        .inValid  (inValid),
        .inReady  (inReady),
        .funct    (funct),
        .rs       (rs),
        .rt       (rt),
        .outValid (outValid),
        .outReady (outReady),
        .outData  (outData)
    );

    always #20 clk = ~clk;

    initial begin
        void'($urandom(32'h467c));
        forever begin
            @(negedge clk);
            outReady = ($urandom % 100) < 70;   // Ready on roughly 70 % of cycles
        end
    end

    // Response checker, one line per finished read
    always @(posedge clk) begin
        if (!rst && outValid && outReady) begin
            if (expQ.size() == 0) begin
                $display("Unexpected response %h with no read outstanding", outData);
                errors++;
            end else begin
                checked++;
                if (outData !== expQ[0]) begin
                    $display("Error: %s expected %h actual %h", expNameQ[0], expQ[0], outData);
                    errors++;
                end else begin
                    $display("ok     %s %h", expNameQ[0], outData);
                end
                void'(expQ.pop_front());
                void'(expNameQ.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycleLimit > 0 && cycles >= cycleLimit) begin
            $display("Timeout: run still busy after %0d cycles", cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic loadStimulus();
        int               fd;
        int               cnt;
        int               fl;
        string            line;
        string            nm;
        logic [5:0]       f;
        logic [dataW-1:0] a;
        logic [dataW-1:0] b;
        logic [dataW-1:0] e;
        fd = $fopen("test/mdStimulus.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file test/mdStimulus.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                cnt = $fgets(line, fd);
                if (cnt > 0 && line.getc(0) != 8'h23) begin     // Skip comment lines
                    cnt = $sscanf(line, "%s %h %h %h %h %d", nm, f, a, b, e, fl);
                    if (cnt == 6) begin
                        names.push_back(nm);
                        functs.push_back(f);
                        rsVals.push_back(a);
                        rtVals.push_back(b);
                        expVals.push_back(e);
                        flushFlags.push_back(fl);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Present one instruction on the falling edge and hold it until accepted
    task automatic sendInstr(input int idx);
        logic accepted;
        @(negedge clk);
        inValid = 1'b1;
        funct   = functs[idx];
        rs      = rsVals[idx];
        rt      = rtVals[idx];
        if (functs[idx] == functMfhi || functs[idx] == functMflo) begin
            expQ.push_back(expVals[idx]);
            expNameQ.push_back(names[idx]);
        end
        accepted = 1'b0;
        while (!accepted) begin
            @(posedge clk);
            accepted = inReady;
        end
    endtask

    task automatic waitForResponses();
        int waited;
        waited = 0;
        @(negedge clk);
        inValid = 1'b0;
        while (expQ.size() != 0 && waited < 200) begin
            @(negedge clk);
            waited++;
        end
    endtask

    task automatic flushDivision(input int idx);
        @(negedge clk);
        inValid = 1'b0;
        repeat (9) @(negedge clk);
        flush = 1'b1;                   // Seen by the DUT 10 cycles after acceptance
        @(negedge clk);
        flush = 1'b0;
        $display("flush  %s applied during the division", names[idx]);
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        flush      = 1'b0;
        inValid    = 1'b0;
        funct      = '0;
        rs         = '0;
        rt         = '0;
        outReady   = 1'b0;
        cycles     = 0;
        cycleLimit = 0;
        checked    = 0;
        errors     = 0;
        loadStimulus();
        cycleLimit = 60 * names.size() + 100;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < names.size(); i++) begin
            if (flushFlags[i] != 0) begin
                waitForResponses();     // Nothing older may sit in the pipe
                sendInstr(i);
                flushDivision(i);
            end else begin
                sendInstr(i);
            end
        end
        waitForResponses();
        repeat (20) @(negedge clk);     // Room for a stray extra response

        if (checked == 0) begin
            $display("No read responses were checked");
            errors++;
        end
        if (expQ.size() != 0) begin
            $display("%0d read responses never arrived", expQ.size());
            errors++;
        end
        $display("Checked %0d responses, %0d errors", checked, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- src/mdUnit.sv
/*
 * MIPS32-style multiply/divide unit
 * Decode, execute and result stages joined by valid/ready buses
 */
`timescale 1ns/1ps

module mdUnit (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  logic                    inValid,
    output logic                    inReady,
    input  logic [5:0]              funct,
    input  logic [mdPkg::dataW-1:0] rs,
    input  logic [mdPkg::dataW-1:0] rt,
    output logic                    outValid,
    input  logic                    outReady,
    output logic [mdPkg::dataW-1:0] outData
);

    mdOpIf opBus ();
    mdWbIf wbBus ();

    mdDecode i_mdDecode (
        .clk     (clk),
        .rst     (rst),
        .flush   (flush),
        .inValid (inValid),
        .inReady (inReady),
        .funct   (funct),
        .rs      (rs),
        .rt      (rt),
        .op      (opBus)
    );

    mdExecute i_mdExecute (
        .clk   (clk),
        .rst   (rst),
        .flush (flush),
        .op    (opBus),
        .wb    (wbBus)
    );

    mdResult i_mdResult (
        .clk      (clk),
        .rst      (rst),
        .wb       (wbBus),
        .outValid (outValid),
        .outReady (outReady),
        .outData  (outData)
    );

endmodule

//--- src/mdResult.sv
/*
 * Multiply/divide result stage
 * Architectural HI/LO registers and the registered read response
 */
`timescale 1ns/1ps

module mdResult (
    input  logic                    clk,
    input  logic                    rst,
    mdWbIf.sink                     wb,
    output logic                    outValid,
    input  logic                    outReady,
    output logic [mdPkg::dataW-1:0] outData
);
    import mdPkg::*;

    logic [dataW-1:0] hiReg;
    logic [dataW-1:0] loReg;
    logic             wbFire;

    // Only a read can be blocked, and only by a response still waiting
    assign wb.ready = !(outValid && !outReady && wb.valid && wb.rd);
    assign wbFire   = wb.valid && wb.ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hiReg    <= '0;
            loReg    <= '0;
            outValid <= 1'b0;
        end else begin
            if (wbFire && wb.wrHi) begin
                hiReg <= wb.hi;
            end
            if (wbFire && wb.wrLo) begin
                loReg <= wb.lo;
            end
            if (wbFire && wb.rd) begin
                outValid <= 1'b1;
            end else if (outReady) begin
                outValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wbFire && wb.rd) begin
            outData <= wb.rdHi ? hiReg : loReg;
        end
    end

    // A read beat never carries a register write
    readNoWrite: assert property (@(posedge clk) disable iff (rst)
        wb.valid && wb.rd |-> !wb.wrHi && !wb.wrLo);

endmodule

//--- src/mdExecute.sv
/*
 * Multiply/divide execute stage
 * Single-cycle multiplies and moves, divider sequencing, and HI/LO beats
 */
`timescale 1ns/1ps

module mdExecute (
    input  logic  clk,
    input  logic  rst,
    input  logic  flush,
    mdOpIf.sink   op,
    mdWbIf.source wb
);
    import mdPkg::*;

    logic                      divRunning;
    logic                      divStart;
    logic                      divDone;
    logic [dataW-1:0]          quotient;
    logic [dataW-1:0]          remainder;
    logic                      accept;
    logic                      isDiv;
    logic signed [2*dataW-1:0] prodS;
    logic [2*dataW-1:0]        prodU;
    logic [2*dataW-1:0]        product;

    assign op.ready = !divRunning && (!wb.valid || wb.ready);
    assign accept   = op.valid && op.ready && !flush;
    assign isDiv    = (op.op == opDiv) || (op.op == opDivu);
    assign divStart = accept && isDiv;

    assign prodS   = $signed(op.a) * $signed(op.b);
    assign prodU   = op.a * op.b;
    assign product = (op.op == opMult) ? prodS : prodU;

    mdDivider i_mdDivider (
        .clk       (clk),
        .rst       (rst),
        .abort     (flush),
        .start     (divStart),
        .signedDiv (op.op == opDiv),
        .dividend  (op.a),
        .divisor   (op.b),
        .done      (divDone),
        .quotient  (quotient),
        .remainder (remainder)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb.valid   <= 1'b0;
            divRunning <= 1'b0;
        end else if (flush) begin
            wb.valid   <= 1'b0;
            divRunning <= 1'b0;
        end else begin
            if (divStart) begin
                divRunning <= 1'b1;
            end else if (divDone) begin
                divRunning <= 1'b0;
            end
            if (divDone || (accept && !isDiv)) begin
                wb.valid <= 1'b1;
            end else if (wb.ready) begin
                wb.valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (divDone) begin
            wb.wrHi <= 1'b1;
            wb.wrLo <= 1'b1;
            wb.hi   <= remainder;
            wb.lo   <= quotient;
            wb.rd   <= 1'b0;
            wb.rdHi <= 1'b0;
        end else if (accept && !isDiv) begin
            wb.wrHi <= op.op inside {opMult, opMultu, opMthi};
            wb.wrLo <= op.op inside {opMult, opMultu, opMtlo};
            wb.hi   <= (op.op == opMthi) ? op.a : product[2*dataW-1:dataW];
            wb.lo   <= (op.op == opMtlo) ? op.a : product[dataW-1:0];
            wb.rd   <= op.op inside {opMfhi, opMflo};
            wb.rdHi <= (op.op == opMfhi);
        end
    end

    wbHold: assert property (@(posedge clk) disable iff (rst)
        wb.valid && !wb.ready && !flush |=> wb.valid
            && $stable({wb.wrHi, wb.wrLo, wb.hi, wb.lo, wb.rd, wb.rdHi}));

endmodule

//--- src/mdDivider.sv
/*
 * Iterative restoring divider
 * Works on magnitudes, one quotient bit per cycle, then restores the signs
 * A zero divisor finishes early with zero quotient and remainder
 */
`timescale 1ns/1ps

module mdDivider (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    abort,
    input  logic                    start,
    input  logic                    signedDiv,
    input  logic [mdPkg::dataW-1:0] dividend,
    input  logic [mdPkg::dataW-1:0] divisor,
    output logic                    done,
    output logic [mdPkg::dataW-1:0] quotient,
    output logic [mdPkg::dataW-1:0] remainder
);
    import mdPkg::*;

    divState            state;
    logic [divCntW-1:0] cnt;
    logic [dataW-1:0]   rem;
    logic [dataW-1:0]   quo;        // Dividend bits shift out, quotient bits shift in
    logic [dataW-1:0]   dvs;
    logic               negQuo;
    logic               negRem;
    logic [dataW-1:0]   absDividend;
    logic [dataW-1:0]   absDivisor;
    logic [dataW:0]     partial;
    logic [dataW+1:0]   diff;

    assign absDividend = (signedDiv && dividend[dataW-1]) ? -dividend : dividend;
    assign absDivisor  = (signedDiv && divisor[dataW-1]) ? -divisor : divisor;

    assign partial = {rem, quo[dataW-1]};
    assign diff    = {1'b0, partial} - {2'b00, dvs};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= divIdle;
            cnt   <= '0;
        end else if (abort) begin
            state <= divIdle;
            cnt   <= '0;
        end else begin
            case (state)
                divIdle: begin
                    if (start) begin
                        state <= (divisor == '0) ? divZero : divRun;
                        cnt   <= '0;
                    end
                end
                divZero: state <= divIdle;
                divRun: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == divCntW'(divCycles - 1)) begin
                        state <= divFix;
                    end
                end
                divFix: state <= divIdle;
                default: state <= divIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == divIdle && start) begin
            rem    <= '0;
            quo    <= absDividend;
            dvs    <= absDivisor;
            negQuo <= signedDiv && (dividend[dataW-1] ^ divisor[dataW-1]);
            negRem <= signedDiv && dividend[dataW-1];   // Remainder follows dividend
        end else if (state == divRun) begin
            rem <= diff[dataW+1] ? partial[dataW-1:0] : diff[dataW-1:0];
            quo <= {quo[dataW-2:0], !diff[dataW+1]};
        end
    end

    // Sign fix-up happens on the way out during the last cycle
    assign done      = (state == divZero) || (state == divFix);
    assign quotient  = (state == divZero) ? '0 : (negQuo ? -quo : quo);
    assign remainder = (state == divZero) ? '0 : (negRem ? -rem : rem);

    startWhenIdle: assert property (@(posedge clk) disable iff (rst)
        start |-> state == divIdle);

endmodule

//--- src/mdDecode.sv
/*
 * Multiply/divide decode stage
 * One-entry input register that maps the function code to an operation
 */
`timescale 1ns/1ps

module mdDecode (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  logic                    inValid,
    output logic                    inReady,
    input  logic [5:0]              funct,
    input  logic [mdPkg::dataW-1:0] rs,
    input  logic [mdPkg::dataW-1:0] rt,
    mdOpIf.source                   op
);
    import mdPkg::*;

    mdOp  decOp;
    logic known;
    logic accept;

    always_comb begin
        known = 1'b1;
        decOp = opMult;
        case (funct)
            functMult:  decOp = opMult;
            functMultu: decOp = opMultu;
            functDiv:   decOp = opDiv;
            functDivu:  decOp = opDivu;
            functMthi:  decOp = opMthi;
            functMtlo:  decOp = opMtlo;
            functMfhi:  decOp = opMfhi;
            functMflo:  decOp = opMflo;
            default:    known = 1'b0;   // Taken and discarded
        endcase
    end

    assign inReady = !op.valid || op.ready;
    assign accept  = inValid && inReady;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            op.valid <= 1'b0;
        end else if (accept) begin
            op.valid <= known;
        end else if (flush || op.ready) begin
            op.valid <= 1'b0;          // Drained or dropped
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op.op <= decOp;
            op.a  <= rs;
            op.b  <= rt;
        end
    end

    // Upstream holds an offered instruction until it is taken
    inHold: assert property (@(posedge clk) disable iff (rst)
        inValid && !inReady |=> inValid && $stable(funct) && $stable(rs) && $stable(rt));

endmodule

//--- src/mdIf.sv
/*
 * Internal buses of the multiply/divide unit
 * mdOpIf carries a decoded operation, mdWbIf a HI/LO write or read beat
 */
`timescale 1ns/1ps

interface mdOpIf;
    import mdPkg::*;

    logic             valid;
    logic             ready;
    mdOp              op;
    logic [dataW-1:0] a;
    logic [dataW-1:0] b;

    modport source (output valid, op, a, b, input ready);
    modport sink   (input valid, op, a, b, output ready);
endinterface

interface mdWbIf;
    import mdPkg::*;

    logic             valid;
    logic             ready;
    logic             wrHi;
    logic             wrLo;
    logic [dataW-1:0] hi;
    logic [dataW-1:0] lo;
    logic             rd;
    logic             rdHi;     // Read selects HI when set, else LO

    modport source (output valid, wrHi, wrLo, hi, lo, rd, rdHi, input ready);
    modport sink   (input valid, wrHi, wrLo, hi, lo, rd, rdHi, output ready);
endinterface

//--- src/mdPkg.sv
/*
 * Multiply/divide unit shared definitions
 * Register width, decoded operations, MIPS function codes and divider sequencing
 */
package mdPkg;

    localparam int dataW = 32;

    // Decoded operation carried from decode to execute
    typedef enum logic [2:0] {
        opMult,
        opMultu,
        opDiv,
        opDivu,
        opMthi,
        opMtlo,
        opMfhi,
        opMflo
    } mdOp;

    // SPECIAL function field encodings
    localparam logic [5:0] functMfhi  = 6'h10;
    localparam logic [5:0] functMthi  = 6'h11;
    localparam logic [5:0] functMflo  = 6'h12;
    localparam logic [5:0] functMtlo  = 6'h13;
    localparam logic [5:0] functMult  = 6'h18;
    localparam logic [5:0] functMultu = 6'h19;
    localparam logic [5:0] functDiv   = 6'h1A;
    localparam logic [5:0] functDivu  = 6'h1B;

    localparam int divCycles = 32;                  // One quotient bit per step
    localparam int divCntW   = $clog2(divCycles);

    typedef enum logic [1:0] {
        divIdle,
        divZero,
        divRun,
        divFix
    } divState;

endpackage
